// File: design/pwl_macros.svh
`ifndef PWL_MACROS_SVH
`define PWL_MACROS_SVH

// Width of one DAC sample.
`define PWL_SAMPLE_WIDTH 16

// Samples per output batch.
`define PWL_BATCH_SIZE 8

// Entries in each wave memory.
`define PWL_SPARSE_DEPTH 64
`define PWL_DENSE_DEPTH 64

// Read latency of wave_memory.
`define PWL_MEM_DELAY 2

// Latency from x and slope to a finished batch.
`define PWL_INTRP_DELAY 3

`endif

// File: design/pwl_pkg.sv
`include "pwl_macros.svh"

package pwl_pkg;

	typedef logic [`PWL_SAMPLE_WIDTH-1:0] sample_t;
	typedef sample_t [`PWL_BATCH_SIZE-1:0] batch_t;
	typedef logic [`PWL_SAMPLE_WIDTH-1:0] dt_t;

	typedef logic [$clog2(`PWL_SPARSE_DEPTH)-1:0] sparse_addr_t;
	typedef logic [$clog2(`PWL_DENSE_DEPTH)-1:0] dense_addr_t;
	typedef logic [$clog2(`PWL_SPARSE_DEPTH+`PWL_DENSE_DEPTH+1)-1:0] region_count_t;

	typedef struct packed {
		sample_t x;
		sample_t slope;
		dt_t dt;
		logic sparse;
	} dma_cmd_t;

	typedef struct packed {
		dma_cmd_t cmd;
		logic next_sparse;
	} sparse_entry_t;

	typedef struct packed {
		batch_t batch;
		logic next_sparse;
	} dense_entry_t;

	// Follows a dense command through the interpolator.
	typedef struct packed {
		logic valid;
		dt_t dt;
		logic next_sparse;
	} intrp_tag_t;

	// One expansion step of a held sparse command.
	typedef struct packed {
		logic valid;
		sample_t x;
		sample_t slope;
	} hold_step_t;

	typedef struct packed {
		logic valid;
		logic sparse;
	} sel_tag_t;

	typedef enum logic [1:0] {LD_EMPTY, LD_LOADING, LD_FINISH, LD_LOADED} loader_state_t;

	typedef enum logic [2:0] {
		IDLE, FETCH, SEND_DENSE, SEND_SPARSE, HOLD_SPARSE, HALT
	} player_state_t;

endpackage

// File: design/slope_interpolator.sv
`timescale 1ns/1ns
`include "pwl_macros.svh"

module slope_interpolator (
	input logic clk,
	input pwl_pkg::sample_t x,
	input pwl_pkg::sample_t slope,
	output pwl_pkg::batch_t intrp_batch
);

	pwl_pkg::batch_t ramp;
	pwl_pkg::batch_t sum;
	pwl_pkg::sample_t x_d;

	// Slope times slot index.
	always_ff @(posedge clk) begin
		x_d <= x;
		for (int i = 0; i < `PWL_BATCH_SIZE; i++) begin
			ramp[i] <= pwl_pkg::sample_t'(slope * i);
		end
	end

	// Offset by the start value, wrapping at sample width.
	always_ff @(posedge clk) begin
		for (int i = 0; i < `PWL_BATCH_SIZE; i++) begin
			sum[i] <= x_d + ramp[i];
		end
	end

	always_ff @(posedge clk) begin
		intrp_batch <= sum;
	end

endmodule

// File: design/wave_memory.sv
`timescale 1ns/1ns
`include "pwl_macros.svh"

module wave_memory #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH = 64
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic [$clog2(DEPTH)-1:0] wr_addr,
	input logic [DATA_WIDTH-1:0] wr_data,
	input logic rd_en,
	input logic [$clog2(DEPTH)-1:0] rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data,
	output logic rd_valid
);

	logic [DATA_WIDTH-1:0] mem [DEPTH];
	logic [DATA_WIDTH-1:0] data_pipe [`PWL_MEM_DELAY];
	logic [`PWL_MEM_DELAY-1:0] valid_pipe;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Block RAM read followed by output registers.
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[rd_addr];
		for (int i = 1; i < `PWL_MEM_DELAY; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[`PWL_MEM_DELAY-2:0], rd_en};
		end
	end

	assign rd_data = data_pipe[`PWL_MEM_DELAY-1];
	assign rd_valid = valid_pipe[`PWL_MEM_DELAY-1];

	// Loader and player never own the memory at once.
	assert property (@(posedge clk) disable iff (rst) !(wr_en && rd_en));

endmodule

// File: design/pwl_loader.sv
`timescale 1ns/1ns
`include "pwl_macros.svh"

module pwl_loader (
	input logic clk,
	input logic rst,
	input pwl_pkg::dma_cmd_t dma_cmd,
	input logic dma_valid,
	input logic dma_last,
	output logic dma_ready,
	output pwl_pkg::sample_t intrp_x,
	output pwl_pkg::sample_t intrp_slope,
	input pwl_pkg::batch_t intrp_batch,
	output logic sparse_wr_en,
	output pwl_pkg::sparse_addr_t sparse_wr_addr,
	output pwl_pkg::sparse_entry_t sparse_wr_data,
	output logic dense_wr_en,
	output pwl_pkg::dense_addr_t dense_wr_addr,
	output pwl_pkg::dense_entry_t dense_wr_data,
	output pwl_pkg::region_count_t region_count,
	output logic first_sparse,
	output logic loaded
);

	pwl_pkg::loader_state_t state;
	pwl_pkg::dma_cmd_t cur;
	logic cur_valid;
	logic cur_last;
	logic alive;
	pwl_pkg::intrp_tag_t tag_pipe [`PWL_INTRP_DELAY+1];
	pwl_pkg::intrp_tag_t tag_out;
	pwl_pkg::batch_t pack;
	pwl_pkg::batch_t pack_next;
	pwl_pkg::dt_t fill;
	logic busy;
	logic beat;
	logic retire;
	logic next_flag;
	logic fill_done;

	assign tag_out = tag_pipe[`PWL_INTRP_DELAY];

	always_comb begin
		busy = dense_wr_en;
		for (int i = 0; i <= `PWL_INTRP_DELAY; i++) begin
			busy = busy | tag_pipe[i].valid;
		end
	end

	// Lookahead full and the held command still blocked.
	assign dma_ready = alive && state != pwl_pkg::LD_FINISH
		&& !(cur_valid && (cur_last || (!cur.sparse && busy)));
	assign beat = dma_valid && dma_ready;
	assign retire = cur_valid && (beat || (cur_last && (cur.sparse || !busy)));
	// The final command points back at the first one.
	assign next_flag = cur_last ? first_sparse : dma_cmd.sparse;
	assign loaded = state == pwl_pkg::LD_LOADED;

	// Drop the first dt samples in at the fill offset.
	always_comb begin
		pack_next = pack;
		for (int i = 0; i < `PWL_BATCH_SIZE; i++) begin
			if (i >= int'(fill) && i < int'(fill) + int'(tag_out.dt)) begin
				pack_next[i] = intrp_batch[i - int'(fill)];
			end
		end
	end

	assign fill_done = tag_out.valid && (fill + tag_out.dt == pwl_pkg::dt_t'(`PWL_BATCH_SIZE));

	always_ff @(posedge clk) begin
		if (retire) begin
			intrp_x <= cur.x;
			intrp_slope <= cur.slope;
		end
		if (beat) begin
			cur <= dma_cmd;
			cur_last <= dma_last;
		end
		if (tag_out.valid) begin
			pack <= pack_next;
		end
		sparse_wr_data <= '{cmd: cur, next_sparse: next_flag};
		dense_wr_data <= '{batch: pack_next, next_sparse: tag_out.next_sparse};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= pwl_pkg::LD_EMPTY;
			alive <= 1'b0;
			cur_valid <= 1'b0;
			for (int i = 0; i <= `PWL_INTRP_DELAY; i++) begin
				tag_pipe[i] <= '0;
			end
			fill <= '0;
			sparse_wr_en <= 1'b0;
			dense_wr_en <= 1'b0;
			sparse_wr_addr <= '0;
			dense_wr_addr <= '0;
			region_count <= '0;
			first_sparse <= 1'b0;
		end else begin
			alive <= 1'b1;
			if (beat) begin
				cur_valid <= 1'b1;
			end else if (retire) begin
				cur_valid <= 1'b0;
			end

			tag_pipe[0] <= '{valid: retire && !cur.sparse, dt: cur.dt, next_sparse: next_flag};
			for (int i = 1; i <= `PWL_INTRP_DELAY; i++) begin
				tag_pipe[i] <= tag_pipe[i-1];
			end

			if (tag_out.valid) begin
				fill <= fill_done ? '0 : fill + tag_out.dt;
			end
			sparse_wr_en <= retire && cur.sparse;
			dense_wr_en <= fill_done;

			if (sparse_wr_en) begin
				sparse_wr_addr <= sparse_wr_addr + 1'b1;
			end
			if (dense_wr_en) begin
				dense_wr_addr <= dense_wr_addr + 1'b1;
			end
			region_count <= region_count + pwl_pkg::region_count_t'(sparse_wr_en)
				+ pwl_pkg::region_count_t'(dense_wr_en);

			case (state)
				pwl_pkg::LD_LOADING: begin
					if (retire && cur_last) begin
						state <= pwl_pkg::LD_FINISH;
					end
				end
				pwl_pkg::LD_FINISH: begin
					if (!busy && !sparse_wr_en) begin
						state <= pwl_pkg::LD_LOADED;
					end
				end
				default: begin
					// First beat of a new waveform.
					if (beat) begin
						state <= pwl_pkg::LD_LOADING;
						first_sparse <= dma_cmd.sparse;
						sparse_wr_addr <= '0;
						dense_wr_addr <= '0;
						region_count <= '0;
						fill <= '0;
					end
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		tag_out.valid |-> fill + tag_out.dt <= pwl_pkg::dt_t'(`PWL_BATCH_SIZE));

endmodule

// File: design/pwl_player.sv
`timescale 1ns/1ns
`include "pwl_macros.svh"

module pwl_player (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halt,
	input pwl_pkg::region_count_t region_count,
	input logic first_sparse,
	input logic loaded,
	output logic active,
	output logic sparse_rd_en,
	output pwl_pkg::sparse_addr_t sparse_rd_addr,
	input pwl_pkg::sparse_entry_t sparse_rd_data,
	input logic sparse_rd_valid,
	output logic dense_rd_en,
	output pwl_pkg::dense_addr_t dense_rd_addr,
	input pwl_pkg::dense_entry_t dense_rd_data,
	input logic dense_rd_valid,
	output pwl_pkg::sample_t intrp_x,
	output pwl_pkg::sample_t intrp_slope,
	input pwl_pkg::batch_t intrp_batch,
	output pwl_pkg::batch_t batch_out,
	output logic valid_batch_out,
	output logic rdy_to_run
);

	pwl_pkg::player_state_t state;
	pwl_pkg::region_count_t region_idx;
	logic cur_sparse;
	pwl_pkg::sample_t x_reg;
	pwl_pkg::sample_t slope_reg;
	pwl_pkg::dt_t dt_reg;
	logic next_reg;
	pwl_pkg::hold_step_t hold_pipe [`PWL_MEM_DELAY];
	pwl_pkg::hold_step_t hold_out;
	pwl_pkg::sel_tag_t sel_pipe [`PWL_INTRP_DELAY];
	pwl_pkg::batch_t dense_line [`PWL_INTRP_DELAY];
	logic streaming;
	logic advance;
	logic adv_next;
	pwl_pkg::dt_t batch_dt;

	assign batch_dt = pwl_pkg::dt_t'(`PWL_BATCH_SIZE);
	assign active = state != pwl_pkg::IDLE;
	assign rdy_to_run = state == pwl_pkg::IDLE && loaded;
	assign streaming = active && state != pwl_pkg::HALT;
	assign sparse_rd_en = state == pwl_pkg::FETCH && cur_sparse && !halt;
	assign dense_rd_en = state == pwl_pkg::FETCH && !cur_sparse && !halt;
	assign hold_out = hold_pipe[`PWL_MEM_DELAY-1];

	// Sparse reads and hold steps reach the interpolator at the same depth.
	assign intrp_x = sparse_rd_valid ? sparse_rd_data.cmd.x : hold_out.x;
	assign intrp_slope = sparse_rd_valid ? sparse_rd_data.cmd.slope : hold_out.slope;

	assign valid_batch_out = sel_pipe[`PWL_INTRP_DELAY-1].valid;
	assign batch_out = sel_pipe[`PWL_INTRP_DELAY-1].sparse ? intrp_batch
		: dense_line[`PWL_INTRP_DELAY-1];

	// Current region has sent its last batch.
	always_comb begin
		advance = 1'b0;
		adv_next = next_reg;
		case (state)
			pwl_pkg::SEND_DENSE: begin
				advance = dense_rd_valid;
				adv_next = dense_rd_data.next_sparse;
			end
			pwl_pkg::SEND_SPARSE: begin
				advance = sparse_rd_valid && sparse_rd_data.cmd.dt <= batch_dt;
				adv_next = sparse_rd_data.next_sparse;
			end
			pwl_pkg::HOLD_SPARSE: advance = dt_reg == batch_dt;
			default: advance = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		for (int i = 1; i < `PWL_INTRP_DELAY; i++) begin
			dense_line[i] <= dense_line[i-1];
		end
		dense_line[0] <= dense_rd_data.batch;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= pwl_pkg::IDLE;
			for (int i = 0; i < `PWL_MEM_DELAY; i++) begin
				hold_pipe[i] <= '0;
			end
			for (int i = 0; i < `PWL_INTRP_DELAY; i++) begin
				sel_pipe[i] <= '0;
			end
			region_idx <= '0;
			sparse_rd_addr <= '0;
			dense_rd_addr <= '0;
			cur_sparse <= 1'b0;
		end else begin
			hold_pipe[0] <= '{valid: state == pwl_pkg::HOLD_SPARSE && !halt,
				x: x_reg, slope: slope_reg};
			for (int i = 1; i < `PWL_MEM_DELAY; i++) begin
				hold_pipe[i] <= hold_pipe[i-1];
			end
			sel_pipe[0] <= '{valid: streaming
				&& (dense_rd_valid || sparse_rd_valid || hold_out.valid),
				sparse: !dense_rd_valid};
			for (int i = 1; i < `PWL_INTRP_DELAY; i++) begin
				sel_pipe[i] <= sel_pipe[i-1];
			end

			case (state)
				pwl_pkg::IDLE: begin
					if (run && loaded) begin
						region_idx <= '0;
						sparse_rd_addr <= '0;
						dense_rd_addr <= '0;
						cur_sparse <= first_sparse;
						state <= pwl_pkg::FETCH;
					end
				end
				pwl_pkg::FETCH: begin
					state <= cur_sparse ? pwl_pkg::SEND_SPARSE : pwl_pkg::SEND_DENSE;
				end
				pwl_pkg::SEND_DENSE: begin
					if (dense_rd_valid) begin
						dense_rd_addr <= dense_rd_addr + 1'b1;
					end
				end
				pwl_pkg::SEND_SPARSE: begin
					if (sparse_rd_valid) begin
						sparse_rd_addr <= sparse_rd_addr + 1'b1;
						if (sparse_rd_data.cmd.dt > batch_dt) begin
							x_reg <= sparse_rd_data.cmd.x
								+ pwl_pkg::sample_t'(sparse_rd_data.cmd.slope * `PWL_BATCH_SIZE);
							slope_reg <= sparse_rd_data.cmd.slope;
							dt_reg <= sparse_rd_data.cmd.dt - batch_dt;
							next_reg <= sparse_rd_data.next_sparse;
							state <= pwl_pkg::HOLD_SPARSE;
						end
					end
				end
				pwl_pkg::HOLD_SPARSE: begin
					x_reg <= x_reg + pwl_pkg::sample_t'(slope_reg * `PWL_BATCH_SIZE);
					dt_reg <= dt_reg - batch_dt;
				end
				default: state <= pwl_pkg::IDLE;
			endcase

			if (advance) begin
				state <= pwl_pkg::FETCH;
				if (region_idx == region_count - 1'b1) begin
					// Wrap to the start of the waveform.
					region_idx <= '0;
					sparse_rd_addr <= '0;
					dense_rd_addr <= '0;
					cur_sparse <= first_sparse;
				end else begin
					region_idx <= region_idx + 1'b1;
					cur_sparse <= adv_next;
				end
			end
			if (halt && streaming) begin
				state <= pwl_pkg::HALT;
			end
		end
	end

	// Output only while playing or draining right after a halt.
	assert property (@(posedge clk) disable iff (rst)
		valid_batch_out |-> state != pwl_pkg::IDLE || $past(state == pwl_pkg::HALT)
			|| $past(state == pwl_pkg::HALT, 2));

endmodule

// File: design/pwl_generator.sv
`timescale 1ns/1ns
`include "pwl_macros.svh"

module pwl_generator (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halt,
	input pwl_pkg::dma_cmd_t dma_cmd,
	input logic dma_valid,
	input logic dma_last,
	output logic dma_ready,
	output logic rdy_to_run,
	output pwl_pkg::batch_t batch_out,
	output logic valid_batch_out
);

	logic active;
	pwl_pkg::sample_t ld_x, ld_slope, pl_x, pl_slope, intrp_x, intrp_slope;
	pwl_pkg::batch_t intrp_batch;
	logic ld_sparse_wr_en, ld_dense_wr_en, pl_sparse_rd_en, pl_dense_rd_en;
	pwl_pkg::sparse_addr_t sparse_wr_addr, sparse_rd_addr;
	pwl_pkg::dense_addr_t dense_wr_addr, dense_rd_addr;
	pwl_pkg::sparse_entry_t sparse_wr_data, sparse_rd_data;
	pwl_pkg::dense_entry_t dense_wr_data, dense_rd_data;
	logic sparse_rd_valid, dense_rd_valid;
	pwl_pkg::region_count_t region_count;
	logic first_sparse, loaded;

	// Loader drives the interpolator while the player is idle.
	assign intrp_x = active ? pl_x : ld_x;
	assign intrp_slope = active ? pl_slope : ld_slope;

	pwl_loader loader_i (
		.clk(clk), .rst(rst),
		.dma_cmd(dma_cmd), .dma_valid(dma_valid), .dma_last(dma_last), .dma_ready(dma_ready),
		.intrp_x(ld_x), .intrp_slope(ld_slope), .intrp_batch(intrp_batch),
		.sparse_wr_en(ld_sparse_wr_en), .sparse_wr_addr(sparse_wr_addr),
		.sparse_wr_data(sparse_wr_data),
		.dense_wr_en(ld_dense_wr_en), .dense_wr_addr(dense_wr_addr),
		.dense_wr_data(dense_wr_data),
		.region_count(region_count), .first_sparse(first_sparse), .loaded(loaded)
	);

	pwl_player player_i (
		.clk(clk), .rst(rst), .run(run), .halt(halt),
		.region_count(region_count), .first_sparse(first_sparse), .loaded(loaded),
		.active(active),
		.sparse_rd_en(pl_sparse_rd_en), .sparse_rd_addr(sparse_rd_addr),
		.sparse_rd_data(sparse_rd_data), .sparse_rd_valid(sparse_rd_valid),
		.dense_rd_en(pl_dense_rd_en), .dense_rd_addr(dense_rd_addr),
		.dense_rd_data(dense_rd_data), .dense_rd_valid(dense_rd_valid),
		.intrp_x(pl_x), .intrp_slope(pl_slope), .intrp_batch(intrp_batch),
		.batch_out(batch_out), .valid_batch_out(valid_batch_out), .rdy_to_run(rdy_to_run)
	);

	slope_interpolator intrp_i (
		.clk(clk), .x(intrp_x), .slope(intrp_slope), .intrp_batch(intrp_batch)
	);

	wave_memory #(
		.DATA_WIDTH($bits(pwl_pkg::sparse_entry_t)), .DEPTH(`PWL_SPARSE_DEPTH)
	) sparse_mem_i (
		.clk(clk), .rst(rst),
		.wr_en(ld_sparse_wr_en), .wr_addr(sparse_wr_addr), .wr_data(sparse_wr_data),
		.rd_en(pl_sparse_rd_en), .rd_addr(sparse_rd_addr),
		.rd_data(sparse_rd_data), .rd_valid(sparse_rd_valid)
	);

	wave_memory #(
		.DATA_WIDTH($bits(pwl_pkg::dense_entry_t)), .DEPTH(`PWL_DENSE_DEPTH)
	) dense_mem_i (
		.clk(clk), .rst(rst),
		.wr_en(ld_dense_wr_en), .wr_addr(dense_wr_addr), .wr_data(dense_wr_data),
		.rd_en(pl_dense_rd_en), .rd_addr(dense_rd_addr),
		.rd_data(dense_rd_data), .rd_valid(dense_rd_valid)
	);

endmodule

// File: test/pwl_generator_tb.sv
`timescale 1ns/1ns
`include "pwl_macros.svh"

module pwl_generator_tb;

	localparam int ALL_DENSE = 0;
	localparam int ALL_SPARSE = 1;
	localparam int MIX_SPARSE_FIRST = 2;
	localparam int MIX_DENSE_FIRST = 3;

	logic clk = 1'b0;
	logic rst;
	logic run;
	logic halt;
	pwl_pkg::dma_cmd_t dma_cmd;
	logic dma_valid;
	logic dma_last;
	logic dma_ready;
	logic rdy_to_run;
	pwl_pkg::batch_t batch_out;
	logic valid_batch_out;

	logic [31:0] lfsr_state = 32'h3a19_7ae4;
	pwl_pkg::dma_cmd_t cmd_q[$];
	pwl_pkg::batch_t exp_q[$];
	int exp_idx = 0;
	int got_count = 0;
	int batch_errors = 0;
	int flag_errors = 0;
	int timeout_count = 0;

	pwl_generator dut_i (
		.clk(clk), .rst(rst), .run(run), .halt(halt),
		.dma_cmd(dma_cmd), .dma_valid(dma_valid), .dma_last(dma_last), .dma_ready(dma_ready),
		.rdy_to_run(rdy_to_run), .batch_out(batch_out), .valid_batch_out(valid_batch_out)
	);

	always #10 clk = ~clk;

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic lsb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) begin
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			end
			r = {r[30:0], lsb};
		end
		return r;
	endfunction

	function automatic void gen_wave(input int mode, input int n_groups);
		pwl_pkg::dma_cmd_t cmd;
		logic first;
		logic grp_sparse;
		int remaining;
		cmd_q.delete();
		first = (mode == ALL_SPARSE || mode == MIX_SPARSE_FIRST);
		for (int g = 0; g < n_groups; g++) begin
			if (mode == ALL_DENSE || mode == ALL_SPARSE || g == 0) begin
				grp_sparse = first;
			end else if (g == 1 || g == n_groups - 1) begin
				// Memory change after the start and across the wrap.
				grp_sparse = !first;
			end else begin
				grp_sparse = take_bits(1) != 0;
			end
			if (grp_sparse) begin
				cmd.x = pwl_pkg::sample_t'(take_bits(16));
				cmd.slope = pwl_pkg::sample_t'(take_bits(16));
				cmd.dt = pwl_pkg::dt_t'(`PWL_BATCH_SIZE * (1 + take_bits(2)));
				cmd.sparse = 1'b1;
				cmd_q.push_back(cmd);
			end else begin
				// Dense split of one batch.
				remaining = `PWL_BATCH_SIZE;
				while (remaining > 0) begin
					cmd.x = pwl_pkg::sample_t'(take_bits(16));
					cmd.slope = pwl_pkg::sample_t'(take_bits(16));
					cmd.dt = pwl_pkg::dt_t'(1 + take_bits(2));
					if (int'(cmd.dt) > remaining) begin
						cmd.dt = pwl_pkg::dt_t'(remaining);
					end
					cmd.sparse = 1'b0;
					cmd_q.push_back(cmd);
					remaining -= int'(cmd.dt);
				end
			end
		end
	endfunction

	// Sample j of a command is x + slope * j, cut into batches.
	function automatic void expand_reference();
		pwl_pkg::sample_t stream[$];
		pwl_pkg::batch_t b;
		exp_q.delete();
		foreach (cmd_q[k]) begin
			for (int j = 0; j < int'(cmd_q[k].dt); j++) begin
				stream.push_back(pwl_pkg::sample_t'(cmd_q[k].x + cmd_q[k].slope * j));
			end
		end
		for (int n = 0; n < stream.size() / `PWL_BATCH_SIZE; n++) begin
			for (int i = 0; i < `PWL_BATCH_SIZE; i++) begin
				b[i] = stream[n * `PWL_BATCH_SIZE + i];
			end
			exp_q.push_back(b);
		end
	endfunction

	task automatic check_batch(input string name, input pwl_pkg::batch_t got,
		input pwl_pkg::batch_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
			batch_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
			flag_errors++;
		end
	endtask

	// Output collector.
	always @(negedge clk) begin
		if (run) begin
			exp_idx = 0;
			got_count = 0;
		end else if (!rst && valid_batch_out) begin
			if (exp_q.size() == 0) begin
				$display("A batch came out with no waveform loaded at %0t", $time);
				batch_errors++;
			end else begin
				check_batch("batch_out", batch_out, exp_q[exp_idx]);
				exp_idx = (exp_idx + 1) % exp_q.size();
			end
			got_count++;
		end
	end

	task automatic send_wave(input logic stalls);
		int n_stall;
		int cycles;
		@(posedge clk);
		#2;
		foreach (cmd_q[k]) begin
			n_stall = stalls ? int'(take_bits(2)) : 0;
			dma_valid = 1'b0;
			repeat (n_stall) begin
				@(posedge clk);
				#2;
			end
			dma_cmd = cmd_q[k];
			dma_last = (k == cmd_q.size() - 1);
			dma_valid = 1'b1;
			cycles = 0;
			@(negedge clk);
			while (!dma_ready && cycles < 200) begin
				@(negedge clk);
				cycles++;
			end
			if (!dma_ready) begin
				$display("Timed out waiting for dma_ready on command %0d", k);
				timeout_count++;
			end
			@(posedge clk);
			#2;
		end
		dma_valid = 1'b0;
		dma_last = 1'b0;
	endtask

	task automatic wait_rdy_to_run();
		int cycles;
		cycles = 0;
		while (!rdy_to_run && cycles < 500) begin
			@(negedge clk);
			cycles++;
		end
		if (!rdy_to_run) begin
			$display("Timed out waiting for rdy_to_run");
			timeout_count++;
		end
	endtask

	task automatic wait_batches(input int target);
		int cycles;
		cycles = 0;
		while (got_count < target && cycles < 20 * target + 100) begin
			@(negedge clk);
			cycles++;
		end
		if (got_count < target) begin
			$display("Timed out with %0d of %0d batches received", got_count, target);
			timeout_count++;
		end
	endtask

	task automatic load_wave(input int mode, input int n_groups, input logic stalls);
		gen_wave(mode, n_groups);
		expand_reference();
		send_wave(stalls);
		wait_rdy_to_run();
	endtask

	task automatic start_run();
		@(posedge clk);
		#2;
		run = 1'b1;
		@(posedge clk);
		#2;
		run = 1'b0;
	endtask

	// Halt, then check the drain and ready bounds.
	task automatic stop_and_check();
		@(posedge clk);
		#2;
		halt = 1'b1;
		@(posedge clk);
		#2;
		halt = 1'b0;
		repeat (`PWL_INTRP_DELAY) @(posedge clk);
		@(negedge clk);
		check_flag("valid_batch_out", valid_batch_out, 1'b0);
		@(posedge clk);
		@(negedge clk);
		check_flag("rdy_to_run", rdy_to_run, 1'b1);
	endtask

	initial begin
		rst = 1'b1;
		run = 1'b0;
		halt = 1'b0;
		dma_cmd = '0;
		dma_valid = 1'b0;
		dma_last = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_flag("valid_batch_out", valid_batch_out, 1'b0);
		check_flag("rdy_to_run", rdy_to_run, 1'b0);
		check_flag("dma_ready", dma_ready, 1'b0);
		@(posedge clk);
		#2;
		rst = 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_flag("dma_ready", dma_ready, 1'b1);

		load_wave(ALL_DENSE, 6, 1'b0);
		start_run();
		wait_batches(3 * exp_q.size());
		stop_and_check();

		load_wave(ALL_SPARSE, 5, 1'b0);
		start_run();
		wait_batches(3 * exp_q.size());
		stop_and_check();

		load_wave(MIX_SPARSE_FIRST, 8, 1'b0);
		start_run();
		wait_batches(3 * exp_q.size());
		stop_and_check();

		// Dense start, halted mid pass and replayed from the top.
		load_wave(MIX_DENSE_FIRST, 8, 1'b0);
		start_run();
		wait_batches(3 * exp_q.size());
		stop_and_check();
		start_run();
		wait_batches(exp_q.size() / 2);
		stop_and_check();
		start_run();
		wait_batches(exp_q.size() + 1);
		stop_and_check();

		// Reloads under source stalls.
		load_wave(MIX_SPARSE_FIRST, 10, 1'b1);
		start_run();
		wait_batches(3 * exp_q.size());
		stop_and_check();
		load_wave(MIX_DENSE_FIRST, 10, 1'b1);
		start_run();
		wait_batches(3 * exp_q.size());
		stop_and_check();

		$display("Errors: %0d batch, %0d flag, %0d timeouts",
			batch_errors, flag_errors, timeout_count);
		if (batch_errors == 0 && flag_errors == 0 && timeout_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+design
design/pwl_pkg.sv
design/slope_interpolator.sv
design/wave_memory.sv
design/pwl_loader.sv
design/pwl_player.sv
design/pwl_generator.sv
test/pwl_generator_tb.sv

// File: Bender.yml
package:
  name: pwl_generator

sources:
  - include_dirs:
      - design
    files:
      - design/pwl_pkg.sv
      - design/slope_interpolator.sv
      - design/wave_memory.sv
      - design/pwl_loader.sv
      - design/pwl_player.sv
      - design/pwl_generator.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/pwl_generator_tb.sv
